/* logic/lock_pkg.sv */
`default_nettype none

package lock_pkg;

    // ====================
    // password and digits
    // ====================
    localparam int PWD_LEN = 6;

    typedef logic [3:0] digit_t;
    localparam digit_t DIGIT_BLANK = 4'hF;          // empty slot marker

    typedef logic [PWD_LEN*4-1:0] pwd_t;            // digit 0 in the low nibble
    typedef logic [2:0]           idx_t;            // 0..6

    // ====================
    // switches and keys
    // ====================
    localparam int SW_WIDTH = 10;
    localparam logic [SW_WIDTH-1:0] ADMIN_KEY = 10'b00_0000_1111;

    localparam int MAX_FAILS = 3;                   // third miss locks out

    // lock states
    typedef enum logic [2:0] {
        IDLE,
        ENTRY,
        UNLOCK,
        ERROR,
        LOCKOUT,
        ADMIN_SET
    } lock_state_t;

    // status leds
    typedef logic [15:0] led_t;
    localparam int LED_UNLOCK  = 0;
    localparam int LED_ENTRY   = 1;
    localparam int LED_ADMIN   = 2;
    localparam int LED_ERROR   = 3;
    localparam int LED_LOCKOUT = 15;

endpackage

`default_nettype wire

/* logic/btn_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module btn_sync #(
    parameter int N_BTN = 4
) (
    input  wire              clk,
    input  wire              rstn,
    input  wire  [N_BTN-1:0] btn,      // raw async levels
    output logic [N_BTN-1:0] pulse     // one cycle per press
);

    logic [N_BTN-1:0] sync_s0;
    logic [N_BTN-1:0] sync_s1;
    logic [N_BTN-1:0] pulse_q;

    // ====================
    // two-flop synchronizer
    // ====================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            sync_s0 <= '0;
            sync_s1 <= '0;
        end else begin
            sync_s0 <= btn;
            sync_s1 <= sync_s0;
        end
    end

    // registered rising edge keeps the strobe glitch free
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pulse_q <= '0;
        end else begin
            pulse_q <= sync_s0 & ~sync_s1;
        end
    end

    assign pulse = pulse_q;

endmodule

`default_nettype wire

/* logic/digit_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module digit_buffer (
    input  wire                          clk,
    input  wire                          rstn,
    input  wire  [lock_pkg::SW_WIDTH-1:0] sw,
    input  wire                          buf_write,
    input  wire                          buf_erase,
    input  wire                          buf_clear,
    output lock_pkg::pwd_t               buf_digits,
    output logic                         buf_full
);

    import lock_pkg::*;

    localparam int ONES_W = $clog2(SW_WIDTH + 1);

    digit_t            sw_digit;
    logic [ONES_W-1:0] sw_ones;
    logic              sw_valid;

    digit_t slot [PWD_LEN];
    idx_t   ptr;

    // ====================
    // switch decode
    // ====================
    // the highest switch on gives the digit and the count says if it is alone
    always_comb begin
        sw_digit = DIGIT_BLANK;
        sw_ones  = '0;
        for (int i = 0; i < SW_WIDTH; i++) begin
            if (sw[i]) begin
                sw_digit = digit_t'(i);
                sw_ones  = sw_ones + 1'b1;
            end
        end
    end

    assign sw_valid = (sw_ones == ONES_W'(1));  // exactly one switch on

    // ====================
    // write pointer
    // ====================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ptr <= '0;
        end else if (buf_clear) begin
            ptr <= '0;
        end else if (buf_write) begin
            if (ptr < idx_t'(PWD_LEN) && sw_valid) begin
                ptr <= ptr + 1'b1;
            end
        end else if (buf_erase) begin
            if (ptr != '0) begin
                ptr <= ptr - 1'b1;
            end
        end
    end

    // slot contents follow the same priority as the pointer
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < PWD_LEN; i++) begin
                slot[i] <= DIGIT_BLANK;
            end
        end else if (buf_clear) begin
            for (int i = 0; i < PWD_LEN; i++) begin
                slot[i] <= DIGIT_BLANK;
            end
        end else if (buf_write) begin
            if (ptr < idx_t'(PWD_LEN) && sw_valid) begin
                slot[ptr] <= sw_digit;
            end
        end else if (buf_erase) begin
            if (ptr != '0) begin
                slot[ptr - 1'b1] <= DIGIT_BLANK;  // blank the last stored digit
            end
        end
    end

    // pack slots with slot 0 lowest
    always_comb begin
        for (int i = 0; i < PWD_LEN; i++) begin
            buf_digits[i*4 +: 4] = slot[i];
        end
    end

    assign buf_full = (ptr == idx_t'(PWD_LEN));

endmodule

`default_nettype wire

/* logic/pwd_store.sv */
`timescale 1ns/1ps
`default_nettype none

module pwd_store (
    input  wire             clk,
    input  wire             rstn,
    input  wire  lock_pkg::pwd_t buf_digits,
    input  wire             pwd_load,
    output logic            pwd_match
);

    import lock_pkg::*;

    // 1-2-3-4-5-6 with digit 0 in the low nibble
    localparam pwd_t PWD_INIT = 24'h65_43_21;

    pwd_t               pwd_q;
    logic [PWD_LEN-1:0] digit_eq;

    // ====================
    // password register
    // ====================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pwd_q <= PWD_INIT;
        end else if (pwd_load) begin
            pwd_q <= buf_digits;    // commit from the entry buffer
        end
    end

    // ====================
    // compare
    // ====================
    // per digit equality with no latency
    always_comb begin
        for (int i = 0; i < PWD_LEN; i++) begin
            digit_eq[i] = (buf_digits[i*4 +: 4] == pwd_q[i*4 +: 4]);
        end
    end

    assign pwd_match = &digit_eq;

endmodule

`default_nettype wire

/* logic/lock_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module lock_fsm #(
    parameter int unsigned IDLE_CYCLES   = 1_500_000_000,
    parameter int unsigned UNLOCK_CYCLES = 32'd3_000_000_000,
    parameter int unsigned ERROR_CYCLES  = 300_000_000
) (
    input  wire                          clk,
    input  wire                          rstn,
    input  wire  [lock_pkg::SW_WIDTH-1:0] sw,
    input  wire                          input_pulse,
    input  wire                          confirm_pulse,
    input  wire                          back_pulse,
    input  wire                          admin_pulse,
    input  wire                          buf_full,
    input  wire                          pwd_match,
    output logic                         buf_write,
    output logic                         buf_erase,
    output logic                         buf_clear,
    output logic                         pwd_load,
    output lock_pkg::led_t               led
);

    import lock_pkg::*;

    localparam int IDLE_W   = $clog2(IDLE_CYCLES + 1);
    localparam int UNLOCK_W = $clog2(UNLOCK_CYCLES + 1);
    localparam int ERROR_W  = $clog2(ERROR_CYCLES + 1);
    localparam int FAIL_W   = $clog2(MAX_FAILS);

    lock_state_t state_q, state_d;

    logic [FAIL_W-1:0]   fail_cnt;
    logic                fail_inc;
    logic                fail_rst;
    logic [IDLE_W-1:0]   idle_cnt;
    logic [UNLOCK_W-1:0] unlock_cnt;
    logic [ERROR_W-1:0]  error_cnt;
    logic [SW_WIDTH-1:0] sw_q;

    logic admin_key;
    logic activity;
    logic idle_done;
    logic unlock_done;
    logic error_done;
    logic last_try;
    logic digit_mode;

    assign admin_key  = admin_pulse && (sw == ADMIN_KEY);
    assign activity   = input_pulse | confirm_pulse | back_pulse | admin_pulse | (sw != sw_q);
    assign last_try   = (fail_cnt == FAIL_W'(MAX_FAILS - 1));
    assign digit_mode = (state_q == ENTRY) || (state_q == ADMIN_SET);

    // ====================
    // timers
    // ====================
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            sw_q <= '0;
        end else begin
            sw_q <= sw;
        end
    end

    // entry inactivity restarted by any press or switch move
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            idle_cnt <= '0;
        end else if (state_q != ENTRY || activity) begin
            idle_cnt <= '0;
        end else begin
            idle_cnt <= idle_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            unlock_cnt <= '0;
        end else if (state_q != UNLOCK) begin
            unlock_cnt <= '0;
        end else begin
            unlock_cnt <= unlock_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            error_cnt <= '0;
        end else if (state_q != ERROR) begin
            error_cnt <= '0;
        end else begin
            error_cnt <= error_cnt + 1'b1;
        end
    end

    assign idle_done   = (idle_cnt == IDLE_W'(IDLE_CYCLES - 1)) && !activity;
    assign unlock_done = (unlock_cnt == UNLOCK_W'(UNLOCK_CYCLES - 1));
    assign error_done  = (error_cnt == ERROR_W'(ERROR_CYCLES - 1));

    // ====================
    // next state
    // ====================
    always_comb begin
        state_d   = state_q;
        buf_clear = 1'b0;
        pwd_load  = 1'b0;
        fail_inc  = 1'b0;
        fail_rst  = 1'b0;
        case (state_q)
            IDLE: begin
                if (input_pulse) begin
                    state_d   = ENTRY;
                    buf_clear = 1'b1;
                end else if (admin_key) begin
                    state_d   = ADMIN_SET;
                    buf_clear = 1'b1;
                end
            end
            ENTRY: begin
                if (confirm_pulse && buf_full) begin
                    if (pwd_match) begin
                        state_d  = UNLOCK;
                        fail_rst = 1'b1;
                    end else if (last_try) begin
                        state_d = LOCKOUT;
                    end else begin
                        state_d  = ERROR;
                        fail_inc = 1'b1;
                    end
                end else if (admin_key) begin
                    state_d   = ADMIN_SET;
                    buf_clear = 1'b1;
                end else if (idle_done) begin
                    state_d = IDLE;
                end
            end
            UNLOCK: begin
                if (admin_key) begin
                    state_d   = ADMIN_SET;
                    buf_clear = 1'b1;
                end else if (unlock_done || confirm_pulse) begin
                    state_d = IDLE;
                end
            end
            ERROR: begin
                if (error_done) begin
                    state_d   = ENTRY;  // fresh attempt
                    buf_clear = 1'b1;
                end
            end
            LOCKOUT: begin
                if (admin_key) begin
                    state_d  = IDLE;
                    fail_rst = 1'b1;
                end
            end
            ADMIN_SET: begin
                if (confirm_pulse && buf_full) begin
                    state_d  = IDLE;
                    pwd_load = 1'b1;
                end else if (admin_key) begin
                    state_d = IDLE;     // abort without a store
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state_q  <= IDLE;
            fail_cnt <= '0;
        end else begin
            state_q <= state_d;
            if (fail_rst) begin
                fail_cnt <= '0;
            end else if (fail_inc) begin
                fail_cnt <= fail_cnt + 1'b1;
            end
        end
    end

    // digit strobes only while a code is being keyed
    assign buf_write = confirm_pulse && !buf_full && digit_mode;
    assign buf_erase = back_pulse && digit_mode;

    // ====================
    // led decode
    // ====================
    always_comb begin
        led = '0;
        case (state_q)
            ENTRY:     led[LED_ENTRY]   = 1'b1;
            UNLOCK:    led[LED_UNLOCK]  = 1'b1;
            ERROR:     led[LED_ERROR]   = 1'b1;
            LOCKOUT:   led[LED_LOCKOUT] = 1'b1;
            ADMIN_SET: led[LED_ADMIN]   = 1'b1;
            default:   led = '0;
        endcase
    end

endmodule

`default_nettype wire

/* logic/password_lock.sv */
`timescale 1ns/1ps
`default_nettype none

module password_lock #(
    parameter int unsigned IDLE_CYCLES   = 1_500_000_000,     // 15 s at 100 MHz
    parameter int unsigned UNLOCK_CYCLES = 32'd3_000_000_000, // 30 s
    parameter int unsigned ERROR_CYCLES  = 300_000_000        // 3 s
) (
    input  wire                          clk,
    input  wire                          rstn,
    input  wire  [lock_pkg::SW_WIDTH-1:0] sw,
    input  wire                          input_btn,
    input  wire                          confirm_btn,
    input  wire                          back_btn,
    input  wire                          admin_btn,
    output lock_pkg::led_t               led
);

    import lock_pkg::*;

    logic [3:0] btn_pulse;  // {admin, back, confirm, input}
    logic       buf_write;
    logic       buf_erase;
    logic       buf_clear;
    logic       buf_full;
    logic       pwd_load;
    logic       pwd_match;
    pwd_t       buf_digits;

    // ====================
    // button conditioning
    // ====================
    btn_sync #(
        .N_BTN (4)
    ) u_btn_sync (
        .clk   (clk),
        .rstn  (rstn),
        .btn   ({admin_btn, back_btn, confirm_btn, input_btn}),
        .pulse (btn_pulse)
    );

    digit_buffer u_digit_buffer (
        .clk        (clk),
        .rstn       (rstn),
        .sw         (sw),
        .buf_write  (buf_write),
        .buf_erase  (buf_erase),
        .buf_clear  (buf_clear),
        .buf_digits (buf_digits),
        .buf_full   (buf_full)
    );

    pwd_store u_pwd_store (
        .clk        (clk),
        .rstn       (rstn),
        .buf_digits (buf_digits),
        .pwd_load   (pwd_load),
        .pwd_match  (pwd_match)
    );

    // ====================
    // control
    // ====================
    lock_fsm #(
        .IDLE_CYCLES   (IDLE_CYCLES),
        .UNLOCK_CYCLES (UNLOCK_CYCLES),
        .ERROR_CYCLES  (ERROR_CYCLES)
    ) u_lock_fsm (
        .clk           (clk),
        .rstn          (rstn),
        .sw            (sw),
        .input_pulse   (btn_pulse[0]),
        .confirm_pulse (btn_pulse[1]),
        .back_pulse    (btn_pulse[2]),
        .admin_pulse   (btn_pulse[3]),
        .buf_full      (buf_full),
        .pwd_match     (pwd_match),
        .buf_write     (buf_write),
        .buf_erase     (buf_erase),
        .buf_clear     (buf_clear),
        .pwd_load      (pwd_load),
        .led           (led)
    );

endmodule

`default_nettype wire

/* dv/tb_password_lock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_password_lock;

    import lock_pkg::*;

    localparam int unsigned IDLE_CYCLES   = 400;
    localparam int unsigned UNLOCK_CYCLES = 300;
    localparam int unsigned ERROR_CYCLES  = 60;
    localparam int          MARGIN        = 20;
    localparam pwd_t        RESET_PWD     = 24'h65_43_21;  // 1-2-3-4-5-6

    typedef enum int {EV_INPUT, EV_CONFIRM, EV_BACK, EV_ADMIN, EV_EXPIRE} ev_kind_t;

    logic                clk;
    logic                rstn;
    logic [SW_WIDTH-1:0] sw;
    logic                input_btn;
    logic                confirm_btn;
    logic                back_btn;
    logic                admin_btn;
    led_t                led;

    ev_kind_t            ev_kind_q [$];  // everything pressed since reset
    logic [SW_WIDTH-1:0] ev_sw_q [$];
    event                cmp_ev;
    string               cmp_what;
    int                  n_checks;
    int                  n_errors;
    int                  test_errors;
    integer              seed;
    pwd_t                new_pwd;

    password_lock #(
        .IDLE_CYCLES   (IDLE_CYCLES),
        .UNLOCK_CYCLES (UNLOCK_CYCLES),
        .ERROR_CYCLES  (ERROR_CYCLES)
    ) u_dut (
        .clk         (clk),
        .rstn        (rstn),
        .sw          (sw),
        .input_btn   (input_btn),
        .confirm_btn (confirm_btn),
        .back_btn    (back_btn),
        .admin_btn   (admin_btn),
        .led         (led)
    );

    always #4 clk = ~clk;

    // ====================
    // reference model
    // ====================
    function automatic led_t ref_led(input pwd_t start_pwd);
        lock_state_t         st;
        pwd_t                pw;
        pwd_t                buf_m;
        int                  ptr;
        int                  fails;
        int                  ones;
        digit_t              dig;
        logic [SW_WIDTH-1:0] s;
        led_t                res;
        st    = IDLE;
        pw    = start_pwd;
        buf_m = {PWD_LEN{DIGIT_BLANK}};
        ptr   = 0;
        fails = 0;
        for (int e = 0; e < ev_kind_q.size(); e++) begin
            s    = ev_sw_q[e];
            ones = 0;
            dig  = DIGIT_BLANK;
            for (int b = 0; b < SW_WIDTH; b++) begin
                if (s[b]) begin
                    ones++;
                    dig = digit_t'(b);
                end
            end
            case (ev_kind_q[e])
                EV_INPUT: begin
                    if (st == IDLE) begin
                        st    = ENTRY;
                        buf_m = {PWD_LEN{DIGIT_BLANK}};
                        ptr   = 0;
                    end
                end
                EV_CONFIRM: begin
                    if (st == ENTRY && ptr == PWD_LEN) begin
                        if (buf_m == pw) begin
                            st    = UNLOCK;
                            fails = 0;
                        end else if (fails == MAX_FAILS - 1) begin
                            st = LOCKOUT;
                        end else begin
                            st = ERROR;
                            fails++;
                        end
                    end else if (st == ADMIN_SET && ptr == PWD_LEN) begin
                        pw = buf_m;     // commit new code
                        st = IDLE;
                    end else if (st == UNLOCK) begin
                        st = IDLE;
                    end else if ((st == ENTRY || st == ADMIN_SET) && ones == 1) begin
                        buf_m[ptr*4 +: 4] = dig;
                        ptr++;
                    end
                end
                EV_BACK: begin
                    if ((st == ENTRY || st == ADMIN_SET) && ptr > 0) begin
                        ptr--;
                        buf_m[ptr*4 +: 4] = DIGIT_BLANK;
                    end
                end
                EV_ADMIN: begin
                    if (s == ADMIN_KEY) begin
                        if (st == IDLE || st == ENTRY || st == UNLOCK) begin
                            st    = ADMIN_SET;
                            buf_m = {PWD_LEN{DIGIT_BLANK}};
                            ptr   = 0;
                        end else if (st == LOCKOUT) begin
                            st    = IDLE;
                            fails = 0;
                        end else if (st == ADMIN_SET) begin
                            st = IDLE;  // abort
                        end
                    end
                end
                default: begin          // timer ran out in the current state
                    if (st == ENTRY || st == UNLOCK) begin
                        st = IDLE;
                    end else if (st == ERROR) begin
                        st    = ENTRY;
                        buf_m = {PWD_LEN{DIGIT_BLANK}};
                        ptr   = 0;
                    end
                end
            endcase
        end
        res = '0;
        case (st)
            ENTRY:     res[LED_ENTRY]   = 1'b1;
            UNLOCK:    res[LED_UNLOCK]  = 1'b1;
            ERROR:     res[LED_ERROR]   = 1'b1;
            LOCKOUT:   res[LED_LOCKOUT] = 1'b1;
            ADMIN_SET: res[LED_ADMIN]   = 1'b1;
            default:   res = '0;
        endcase
        return res;
    endfunction

    // ====================
    // compare
    // ====================
    task automatic check_led(input led_t exp, input led_t got, input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[FAIL] %t %s: led %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_state_bit(input int pos, input logic exp, input string what);
        n_checks++;
        if (led[pos] !== exp) begin
            n_errors++;
            $display("[FAIL] %t %s: led[%0d] is %b, expected %b",
                     $time, what, pos, led[pos], exp);
        end
    endtask

    // model against DUT on the falling edge
    initial begin
        forever begin
            @(cmp_ev);
            check_led(ref_led(RESET_PWD), led, cmp_what);
        end
    end

    task automatic expect_model(input string what);
        cmp_what = what;
        -> cmp_ev;
        @(negedge clk);
    endtask

    // ====================
    // stimulus
    // ====================
    function automatic logic [SW_WIDTH-1:0] sw_for_digit(input digit_t d);
        logic [SW_WIDTH-1:0] v;
        v    = '0;
        v[d] = 1'b1;
        return v;
    endfunction

    // 4 cycles high then 4 low from a falling edge
    task automatic press(input ev_kind_t kind, input logic [SW_WIDTH-1:0] sw_val);
        sw = sw_val;
        case (kind)
            EV_INPUT:   input_btn   = 1'b1;
            EV_CONFIRM: confirm_btn = 1'b1;
            EV_BACK:    back_btn    = 1'b1;
            default:    admin_btn   = 1'b1;
        endcase
        repeat (4) @(negedge clk);
        input_btn   = 1'b0;
        confirm_btn = 1'b0;
        back_btn    = 1'b0;
        admin_btn   = 1'b0;
        repeat (4) @(negedge clk);
        ev_kind_q.push_back(kind);
        ev_sw_q.push_back(sw_val);
    endtask

    task automatic enter_code(input pwd_t code);
        for (int i = 0; i < PWD_LEN; i++) begin
            press(EV_CONFIRM, sw_for_digit(code[i*4 +: 4]));
        end
    endtask

    // wait for a timer to move the state and then tell the model
    task automatic wait_expire(input int pos, input logic val, input int limit, input string what);
        int n;
        n = 0;
        while (led[pos] !== val && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (led[pos] !== val) begin
            n_errors++;
            $display("timeout: led[%0d] did not become %b within %0d cycles (%s)",
                     pos, val, limit, what);
        end
        ev_kind_q.push_back(EV_EXPIRE);
        ev_sw_q.push_back(sw);
    endtask

    task automatic report_test(input string name);
        if (n_errors == test_errors) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, n_errors - test_errors);
        end
        test_errors = n_errors;
    endtask

    initial begin
        $timeformat(-9, 0, " ns", 0);
        clk         = 1'b0;
        rstn        = 1'b0;
        sw          = '0;
        input_btn   = 1'b0;
        confirm_btn = 1'b0;
        back_btn    = 1'b0;
        admin_btn   = 1'b0;
        n_checks    = 0;
        n_errors    = 0;
        test_errors = 0;
        seed        = 32'hdd86;
        repeat (3) @(negedge clk);
        rstn = 1'b1;

        // default code
        expect_model("after reset");
        check_led('0, led, "leds off after reset");
        press(EV_INPUT, '0);
        expect_model("input opens entry");
        enter_code(RESET_PWD);
        press(EV_CONFIRM, '0);
        expect_model("default code");
        check_state_bit(LED_UNLOCK, 1'b1, "default code unlocks");
        press(EV_CONFIRM, '0);
        expect_model("confirm relocks");
        report_test("default_unlock");

        // backspace and two switches on
        press(EV_INPUT, '0);
        press(EV_CONFIRM, sw_for_digit(1));
        press(EV_CONFIRM, sw_for_digit(2));
        press(EV_CONFIRM, sw_for_digit(9));
        press(EV_BACK, sw_for_digit(9));
        press(EV_CONFIRM, sw_for_digit(3));
        press(EV_CONFIRM, sw_for_digit(4));
        press(EV_CONFIRM, sw_for_digit(5));
        press(EV_CONFIRM, 10'b00_0010_0001);
        expect_model("two switches ignored");
        check_state_bit(LED_ENTRY, 1'b1, "still keying");
        press(EV_CONFIRM, sw_for_digit(6));
        press(EV_CONFIRM, sw_for_digit(6));
        expect_model("edited code");
        check_state_bit(LED_UNLOCK, 1'b1, "edited code unlocks");
        press(EV_CONFIRM, '0);
        expect_model("relock");
        report_test("backspace_invalid");

        // three misses
        press(EV_INPUT, '0);
        for (int k = 0; k < 2; k++) begin
            enter_code(24'h12_34_56);
            press(EV_CONFIRM, '0);
            expect_model("wrong code");
            check_state_bit(LED_ERROR, 1'b1, "wrong code shows error");
            wait_expire(LED_ENTRY, 1'b1, ERROR_CYCLES + MARGIN, "error to entry");
            expect_model("back to entry");
        end
        enter_code(24'h12_34_56);
        press(EV_CONFIRM, '0);
        expect_model("third miss");
        check_state_bit(LED_LOCKOUT, 1'b1, "third miss locks out");
        press(EV_ADMIN, ADMIN_KEY);
        expect_model("admin clears lockout");
        check_led('0, led, "leds off after lockout");
        report_test("failures");

        // new code from random digits
        for (int i = 0; i < PWD_LEN; i++) begin
            new_pwd[i*4 +: 4] = digit_t'($unsigned($random(seed)) % 10);
        end
        press(EV_ADMIN, ADMIN_KEY);
        expect_model("admin mode");
        check_state_bit(LED_ADMIN, 1'b1, "admin led");
        enter_code(new_pwd);
        press(EV_CONFIRM, '0);
        expect_model("commit");
        press(EV_INPUT, '0);
        enter_code(RESET_PWD);
        press(EV_CONFIRM, '0);
        expect_model("old code after change");
        wait_expire(LED_ENTRY, 1'b1, ERROR_CYCLES + MARGIN, "error to entry");
        enter_code(new_pwd);
        press(EV_CONFIRM, '0);
        expect_model("new code");
        check_state_bit(LED_UNLOCK, 1'b1, "new code unlocks");
        press(EV_CONFIRM, '0);
        press(EV_ADMIN, ADMIN_KEY);
        press(EV_CONFIRM, sw_for_digit(7));
        press(EV_CONFIRM, sw_for_digit(7));
        press(EV_ADMIN, ADMIN_KEY);
        expect_model("aborted change");
        press(EV_INPUT, '0);
        enter_code(new_pwd);
        press(EV_CONFIRM, '0);
        expect_model("code kept after abort");
        press(EV_CONFIRM, '0);
        expect_model("relock");
        report_test("password_change");

        // timers
        press(EV_INPUT, '0);
        expect_model("entry before timeout");
        wait_expire(LED_ENTRY, 1'b0, IDLE_CYCLES + MARGIN, "entry idle timeout");
        expect_model("entry abandoned");
        press(EV_INPUT, '0);
        enter_code(new_pwd);
        press(EV_CONFIRM, '0);
        expect_model("unlock before timeout");
        wait_expire(LED_UNLOCK, 1'b0, UNLOCK_CYCLES + MARGIN, "unlock timeout");
        expect_model("unlock expired");
        report_test("timeouts");

        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
logic/lock_pkg.sv
logic/btn_sync.sv
logic/digit_buffer.sv
logic/pwd_store.sv
logic/lock_fsm.sv
logic/password_lock.sv
dv/tb_password_lock.sv
